//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module rv_core_tb

run: compile
	./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

//--- flist.f
verilog/rv_core_pkg.sv
verilog/rv_control.sv
verilog/rv_pc.sv
verilog/rv_inst_mem.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_imm_gen.sv
verilog/rv_data_mem.sv
verilog/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

//--- sim/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker (
    input logic                   clk,
    input logic                   i_arst_n,
    input logic                   i_setup,
    input rv_core_pkg::word_t     i_pc,
    input logic                   i_rd_we,
    input rv_core_pkg::reg_addr_t i_rd_addr,
    input logic                   i_halted
);

    // failed assertions, read back by the testbench
    int fail_count = 0;

    // fetch only from word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc %h is not word aligned", i_pc);
        end

    // x0 writes are squashed in control
    a_no_x0_write: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_rd_we |-> i_rd_addr != 5'd0)
        else begin
            fail_count++;
            $error("register write enable raised for x0");
        end

    // nothing retires while the program is being loaded
    a_quiet_in_setup: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_setup |-> !i_rd_we)
        else begin
            fail_count++;
            $error("register write during setup");
        end

    a_quiet_when_halted: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_halted && i_rd_we))
        else begin
            fail_count++;
            $error("register write while halted");
        end

endmodule

//--- sim/rv_core_input.txt
# t <name> <start address hex> | p <instruction hex> <asm> | e <rd decimal> <value hex>
# each test runs to ecall, e lines list its register writebacks in order
t arith 00000000
p 00500093 addi x1, x0, 5
p ffd00113 addi x2, x0, -3
p 002081b3 add  x3, x1, x2
p 40208233 sub  x4, x1, x2
p 0020f2b3 and  x5, x1, x2
p 0020e333 or   x6, x1, x2
p 0020c3b3 xor  x7, x1, x2
p 00112433 slt  x8, x2, x1
p 001134b3 sltu x9, x2, x1
p 00108033 add  x0, x1, x1
p 00000073 ecall
e 1 00000005
e 2 fffffffd
e 3 00000002
e 4 00000008
e 5 00000005
e 6 fffffffd
e 7 fffffff8
e 8 00000001
e 9 00000000
t constants 00000000
p 12345537 lui  x10, 0x12345
p 67856513 ori  x10, x10, 0x678
p fff54593 xori x11, x10, -1
p 0ff5f613 andi x12, x11, 0xff
p 0005a693 slti x13, x11, 0
p fffff737 lui  x14, 0xfffff
p fff70713 addi x14, x14, -1
p 00000073 ecall
e 10 12345000
e 10 12345678
e 11 edcba987
e 12 00000087
e 13 00000001
e 14 fffff000
e 14 ffffefff
t memory 00000000
p f0e0d0b7 lui  x1, 0xf0e0d
p 07b08093 addi x1, x1, 0x7b
p 00102823 sw   x1, 16(x0)
p 01002103 lw   x2, 16(x0)
p 01201183 lh   x3, 18(x0)
p 01205203 lhu  x4, 18(x0)
p 01100283 lb   x5, 17(x0)
p 01104303 lbu  x6, 17(x0)
p 01000383 lb   x7, 16(x0)
p 00002a23 sw   x0, 20(x0)
p 00101a23 sh   x1, 20(x0)
p 00100ba3 sb   x1, 23(x0)
p 01402403 lw   x8, 20(x0)
p 00000073 ecall
e 1 f0e0d000
e 1 f0e0d07b
e 2 f0e0d07b
e 3 fffff0e0
e 4 0000f0e0
e 5 ffffffd0
e 6 000000d0
e 7 0000007b
e 8 7b00d07b
t branches 00000000
p 00100093 addi x1, x0, 1
p 00200113 addi x2, x0, 2
p 00208463 beq  x1, x2, +8 not taken
p 00300193 addi x3, x0, 3
p 00209463 bne  x1, x2, +8 taken
p 00400213 addi x4, x0, 4 skipped
p 00114463 blt  x2, x1, +8 not taken
p 00500293 addi x5, x0, 5
p 00115463 bge  x2, x1, +8 taken
p 00600313 addi x6, x0, 6 skipped
p fff00393 addi x7, x0, -1
p 0013c463 blt  x7, x1, +8 taken
p 00800413 addi x8, x0, 8 skipped
p 0013d463 bge  x7, x1, +8 not taken
p 00900493 addi x9, x0, 9
p 00108463 beq  x1, x1, +8 taken
p 00a00513 addi x10, x0, 10 skipped
p 00000073 ecall
e 1 00000001
e 2 00000002
e 3 00000003
e 5 00000005
e 7 ffffffff
e 9 00000009
t jumps 00000100
p 00c000ef jal  x1, +12
p 00300193 addi x3, x0, 3
p 00000073 ecall
p 00200113 addi x2, x0, 2
p 00108267 jalr x4, 1(x1)
e 1 00000104
e 2 00000002
e 4 00000114
e 3 00000003

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int HALT_TIMEOUT = 500;

    logic clk = 1'b0;
    logic i_arst_n, i_setup, i_load_we;
    rv_core_pkg::word_t i_load_addr, i_load_data, i_start_addr;
    rv_core_pkg::word_t o_pc, o_inst, o_rd_data;
    rv_core_pkg::reg_addr_t o_rd_addr;
    logic o_rd_we, o_halted;

    // test table filled from the input file
    string test_name[$];
    rv_core_pkg::word_t test_start[$];
    int prog_first[$], prog_cnt[$], exp_first[$], exp_cnt[$];
    rv_core_pkg::word_t prog_word[$], exp_rd[$], exp_val[$];

    int test_errors, n_pass, n_fail;

    rv_core u_dut (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_setup      (i_setup),
        .i_load_we    (i_load_we),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .i_start_addr (i_start_addr),
        .o_pc         (o_pc),
        .o_inst       (o_inst),
        .o_rd_data    (o_rd_data),
        .o_rd_we      (o_rd_we),
        .o_rd_addr    (o_rd_addr),
        .o_halted     (o_halted)
    );

    bind rv_core rv_core_checker u_checker (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_setup   (i_setup),
        .i_pc      (o_pc),
        .i_rd_we   (o_rd_we),
        .i_rd_addr (o_rd_addr),
        .i_halted  (o_halted)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic check_value(input string name, input rv_core_pkg::word_t expected,
                               input rv_core_pkg::word_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    // t starts a test, p adds a program word, e adds an expected writeback
    task automatic read_tests(output bit ok);
        int fd, k;
        string line, name;
        rv_core_pkg::word_t a, b;
        ok = 1'b0;
        fd = $fopen("sim/rv_core_input.txt", "r");
        if (fd == 0) return;
        while ($fgets(line, fd) != 0) begin
            k = test_name.size() - 1;
            if (line.getc(0) == "t") begin
                void'($sscanf(line, "t %s %h", name, a));
                test_name.push_back(name);
                test_start.push_back(a);
                prog_first.push_back(prog_word.size());
                prog_cnt.push_back(0);
                exp_first.push_back(exp_rd.size());
                exp_cnt.push_back(0);
            end else if (line.getc(0) == "p" && k >= 0) begin
                void'($sscanf(line, "p %h", a));
                prog_word.push_back(a);
                prog_cnt[k] = prog_cnt[k] + 1;
            end else if (line.getc(0) == "e" && k >= 0) begin
                void'($sscanf(line, "e %d %h", a, b));
                exp_rd.push_back(a);
                exp_val.push_back(b);
                exp_cnt[k] = exp_cnt[k] + 1;
            end
        end
        $fclose(fd);
        ok = (test_name.size() > 0);
    endtask

    // reset held over two clock periods
    task automatic reset_core();
        @(negedge clk);
        i_arst_n = 1'b0;
        repeat (2) @(negedge clk);
        i_arst_n = 1'b1;
    endtask

    task automatic run_test(input int k);
        int i, cycles, seen, e;
        test_errors = 0;
        seen = 0;
        cycles = 0;
        reset_core();
        check_value("o_halted", 32'd0, {31'd0, o_halted});
        check_value("o_rd_we", 32'd0, {31'd0, o_rd_we});
        check_value("o_pc", 32'd0, o_pc);
        // load the program, pc follows the start address meanwhile
        i_setup = 1'b1;
        i_start_addr = test_start[k];
        for (i = 0; i < prog_cnt[k]; i++) begin
            i_load_we = 1'b1;
            i_load_addr = test_start[k] + 32'(4 * i);
            i_load_data = prog_word[prog_first[k] + i];
            @(negedge clk);
        end
        i_load_we = 1'b0;
        i_setup = 1'b0;
        // writebacks sampled mid cycle, before the edge that commits them
        while (!o_halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // first instruction shows one cycle after setup drops
            if (cycles == 1) begin
                check_value("o_pc", test_start[k], o_pc);
                check_value("o_inst", prog_word[prog_first[k]], o_inst);
            end
            if (o_rd_we) begin
                if (seen < exp_cnt[k]) begin
                    e = exp_first[k] + seen;
                    check_value("o_rd_addr", exp_rd[e], {27'd0, o_rd_addr});
                    check_value("o_rd_data", exp_val[e], o_rd_data);
                end else begin
                    report_error($sformatf("unexpected extra writeback to x%0d", o_rd_addr));
                end
                seen++;
            end
        end
        if (!o_halted) begin
            report_error($sformatf("core did not halt within %0d cycles", HALT_TIMEOUT));
        end else begin
            // halted core stays quiet
            for (i = 0; i < 3; i++) begin
                @(negedge clk);
                if (o_rd_we) report_error("register writeback after halt");
                if (!o_halted) report_error("halt flag dropped without setup");
            end
        end
        if (seen != exp_cnt[k]) begin
            report_error($sformatf("saw %0d writebacks but expected %0d", seen, exp_cnt[k]));
        end
        if (test_errors == 0) begin
            n_pass++;
            $display("test %s: ok", test_name[k]);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", test_name[k], test_errors);
        end
    endtask

    initial begin
        bit ok;
        int k;
        i_arst_n = 1'b0;
        i_setup = 1'b1;
        i_load_we = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        i_start_addr = '0;
        n_pass = 0;
        n_fail = 0;
        read_tests(ok);
        if (!ok) begin
            $display("could not read any test from sim/rv_core_input.txt");
            n_fail = 1;
        end else begin
            for (k = 0; k < test_name.size(); k++) begin
                run_test(k);
            end
        end
        if (u_dut.u_checker.fail_count != 0) begin
            $display("%0d checker assertions failed", u_dut.u_checker.fail_count);
            n_fail++;
        end
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_core_pkg::alu_op_e i_op,
    input  logic                 i_a_sel_pc,
    input  logic                 i_b_sel_imm,
    input  rv_core_pkg::word_t   i_pc,
    input  rv_core_pkg::word_t   i_rs1,
    input  rv_core_pkg::word_t   i_rs2,
    input  rv_core_pkg::word_t   i_imm,
    output rv_core_pkg::word_t   o_result,
    output logic                 o_eq,
    output logic                 o_lt,
    output logic                 o_ltu
);

    rv_core_pkg::word_t op_a, op_b;

    // operand muxes
    assign op_a = i_a_sel_pc ? i_pc : i_rs1;
    assign op_b = i_b_sel_imm ? i_imm : i_rs2;

    always_comb begin
        case (i_op)
            rv_core_pkg::ALU_ADD:    o_result = op_a + op_b;
            rv_core_pkg::ALU_SUB:    o_result = op_a - op_b;
            rv_core_pkg::ALU_AND:    o_result = op_a & op_b;
            rv_core_pkg::ALU_OR:     o_result = op_a | op_b;
            rv_core_pkg::ALU_XOR:    o_result = op_a ^ op_b;
            rv_core_pkg::ALU_SLT:    o_result = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU:   o_result = {31'd0, op_a < op_b};
            // lui
            rv_core_pkg::ALU_PASS_B: o_result = op_b;
            default:                 o_result = op_a + op_b;
        endcase
    end

    // branch flags always rs1 against rs2, independent of operand muxes
    assign o_eq  = (i_rs1 == i_rs2);
    assign o_lt  = $signed(i_rs1) < $signed(i_rs2);
    assign o_ltu = i_rs1 < i_rs2;

endmodule

//--- verilog/rv_control.sv
`timescale 1ns/1ps

module rv_control (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_setup,
    input  rv_core_pkg::word_t      i_inst,
    input  logic                    i_eq,
    input  logic                    i_lt,
    input  logic                    i_ltu,
    output rv_core_pkg::alu_op_e    o_alu_op,
    output logic                    o_a_sel_pc,
    output logic                    o_b_sel_imm,
    output rv_core_pkg::imm_fmt_e   o_imm_fmt,
    output rv_core_pkg::wb_sel_e    o_wb_sel,
    output logic                    o_reg_we,
    output logic                    o_mem_we,
    output rv_core_pkg::mem_size_e  o_mem_size,
    output logic                    o_mem_unsigned,
    output logic                    o_take_branch,
    output logic                    o_target_from_alu,
    output logic                    o_stall,
    output logic                    o_halted
);

    rv_core_pkg::ctrl_state_e state, state_next;
    rv_core_pkg::opcode_e     opcode;
    rv_core_pkg::alu_op_e     alu_fn;
    rv_core_pkg::br_kind_e    br_kind;
    logic [2:0] funct3;
    logic is_sub, reg_write, mem_write, is_ecall, exec, lt_sel;

    assign opcode = rv_core_pkg::opcode_e'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    // funct7 bit 5 only matters for register ops
    assign is_sub = (opcode == rv_core_pkg::OP_REG) && i_inst[30];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= rv_core_pkg::ST_SETUP;
        end else begin
            state <= state_next;
        end
    end

    // setup wins from any state
    always_comb begin
        state_next = state;
        case (state)
            rv_core_pkg::ST_SETUP: begin
                if (!i_setup) state_next = rv_core_pkg::ST_RUN;
            end
            rv_core_pkg::ST_RUN: begin
                if (i_setup) state_next = rv_core_pkg::ST_SETUP;
                else if (is_ecall) state_next = rv_core_pkg::ST_HALTED;
            end
            rv_core_pkg::ST_HALTED: begin
                if (i_setup) state_next = rv_core_pkg::ST_SETUP;
            end
            default: state_next = rv_core_pkg::ST_SETUP;
        endcase
    end

    // shared alu op for register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = is_sub ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b010:  alu_fn = rv_core_pkg::ALU_SLT;
            3'b011:  alu_fn = rv_core_pkg::ALU_SLTU;
            3'b100:  alu_fn = rv_core_pkg::ALU_XOR;
            3'b110:  alu_fn = rv_core_pkg::ALU_OR;
            3'b111:  alu_fn = rv_core_pkg::ALU_AND;
            default: alu_fn = rv_core_pkg::ALU_ADD;
        endcase
    end

    // main decode
    always_comb begin
        o_alu_op          = rv_core_pkg::ALU_ADD;
        o_a_sel_pc        = 1'b0;
        o_b_sel_imm       = 1'b1;
        o_imm_fmt         = rv_core_pkg::IMM_I;
        o_wb_sel          = rv_core_pkg::WB_ALU;
        o_target_from_alu = 1'b0;
        reg_write         = 1'b0;
        mem_write         = 1'b0;
        is_ecall          = 1'b0;
        br_kind           = rv_core_pkg::BR_NONE;
        case (opcode)
            rv_core_pkg::OP_REG: begin
                o_b_sel_imm = 1'b0;
                o_alu_op    = alu_fn;
                reg_write   = 1'b1;
            end
            rv_core_pkg::OP_IMM: begin
                o_alu_op  = alu_fn;
                reg_write = 1'b1;
            end
            rv_core_pkg::OP_LUI: begin
                o_imm_fmt = rv_core_pkg::IMM_U;
                o_alu_op  = rv_core_pkg::ALU_PASS_B;
                reg_write = 1'b1;
            end
            rv_core_pkg::OP_LOAD: begin
                o_wb_sel  = rv_core_pkg::WB_LOAD;
                reg_write = 1'b1;
            end
            rv_core_pkg::OP_STORE: begin
                o_imm_fmt = rv_core_pkg::IMM_S;
                mem_write = 1'b1;
            end
            rv_core_pkg::OP_BRANCH: begin
                // alu mirrors the pc relative target
                o_imm_fmt  = rv_core_pkg::IMM_B;
                o_a_sel_pc = 1'b1;
                if (!funct3[2]) br_kind = funct3[0] ? rv_core_pkg::BR_NE : rv_core_pkg::BR_EQ;
                else br_kind = funct3[0] ? rv_core_pkg::BR_GE : rv_core_pkg::BR_LT;
            end
            rv_core_pkg::OP_JAL: begin
                o_imm_fmt  = rv_core_pkg::IMM_J;
                o_a_sel_pc = 1'b1;
                o_wb_sel   = rv_core_pkg::WB_LINK;
                reg_write  = 1'b1;
                br_kind    = rv_core_pkg::BR_JUMP;
            end
            rv_core_pkg::OP_JALR: begin
                o_wb_sel          = rv_core_pkg::WB_LINK;
                o_target_from_alu = 1'b1;
                reg_write         = 1'b1;
                br_kind           = rv_core_pkg::BR_JUMP;
            end
            rv_core_pkg::OP_SYSTEM: is_ecall = 1'b1;
            default: ;
        endcase
    end

    // size and sign straight from funct3
    always_comb begin
        case (funct3[1:0])
            2'b00:   o_mem_size = rv_core_pkg::MEM_BYTE;
            2'b01:   o_mem_size = rv_core_pkg::MEM_HALF;
            default: o_mem_size = rv_core_pkg::MEM_WORD;
        endcase
    end
    assign o_mem_unsigned = funct3[2];

    // branch decision, funct3[1] picks the unsigned compare
    assign lt_sel = funct3[1] ? i_ltu : i_lt;
    always_comb begin
        case (br_kind)
            rv_core_pkg::BR_EQ:   o_take_branch = i_eq;
            rv_core_pkg::BR_NE:   o_take_branch = !i_eq;
            rv_core_pkg::BR_LT:   o_take_branch = lt_sel;
            rv_core_pkg::BR_GE:   o_take_branch = !lt_sel;
            rv_core_pkg::BR_JUMP: o_take_branch = 1'b1;
            default:              o_take_branch = 1'b0;
        endcase
    end

    // side effects only while running and out of setup
    assign exec     = (state == rv_core_pkg::ST_RUN) && !i_setup;
    assign o_reg_we = exec && reg_write && (i_inst[11:7] != 5'd0);
    assign o_mem_we = exec && mem_write;
    // pc freezes on ecall and outside run
    assign o_stall  = !exec || is_ecall;
    assign o_halted = (state == rv_core_pkg::ST_HALTED);

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_setup,
    input  logic                   i_load_we,
    input  rv_core_pkg::word_t     i_load_addr,
    input  rv_core_pkg::word_t     i_load_data,
    input  rv_core_pkg::word_t     i_start_addr,
    output rv_core_pkg::word_t     o_pc,
    output rv_core_pkg::word_t     o_inst,
    output rv_core_pkg::word_t     o_rd_data,
    output logic                   o_rd_we,
    output rv_core_pkg::reg_addr_t o_rd_addr,
    output logic                   o_halted
);

    // control lines
    rv_core_pkg::alu_op_e   alu_op;
    rv_core_pkg::imm_fmt_e  imm_fmt;
    rv_core_pkg::wb_sel_e   wb_sel;
    rv_core_pkg::mem_size_e mem_size;
    logic a_sel_pc, b_sel_imm, mem_we, mem_unsigned;
    logic take_branch, target_from_alu, stall;

    // datapath
    rv_core_pkg::word_t pc, pc_plus4, inst, imm, rs1, rs2, alu_result, load_data;
    logic eq, lt, ltu, imem_we;

    // program load only while held in setup
    assign imem_we = i_setup & i_load_we;

    rv_control u_control (
        .clk               (clk),
        .i_arst_n          (i_arst_n),
        .i_setup           (i_setup),
        .i_inst            (inst),
        .i_eq              (eq),
        .i_lt              (lt),
        .i_ltu             (ltu),
        .o_alu_op          (alu_op),
        .o_a_sel_pc        (a_sel_pc),
        .o_b_sel_imm       (b_sel_imm),
        .o_imm_fmt         (imm_fmt),
        .o_wb_sel          (wb_sel),
        .o_reg_we          (o_rd_we),
        .o_mem_we          (mem_we),
        .o_mem_size        (mem_size),
        .o_mem_unsigned    (mem_unsigned),
        .o_take_branch     (take_branch),
        .o_target_from_alu (target_from_alu),
        .o_stall           (stall),
        .o_halted          (o_halted)
    );

    rv_pc u_pc (
        .clk               (clk),
        .i_arst_n          (i_arst_n),
        .i_load_start      (i_setup),
        .i_start_addr      (i_start_addr),
        .i_stall           (stall),
        .i_take_branch     (take_branch),
        .i_target_from_alu (target_from_alu),
        .i_imm             (imm),
        .i_alu_result      (alu_result),
        .o_pc              (pc),
        .o_pc_plus4        (pc_plus4)
    );

    rv_inst_mem u_inst_mem (
        .clk     (clk),
        .i_we    (imem_we),
        .i_waddr (i_load_addr),
        .i_wdata (i_load_data),
        .i_pc    (pc),
        .o_inst  (inst)
    );

    // rd index taken straight from the instruction
    assign o_rd_addr = inst[11:7];

    rv_regfile u_regfile (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_we         (o_rd_we),
        .i_rd_addr    (o_rd_addr),
        .i_rs1_addr   (inst[19:15]),
        .i_rs2_addr   (inst[24:20]),
        .i_wb_sel     (wb_sel),
        .i_alu_result (alu_result),
        .i_load_data  (load_data),
        .i_link       (pc_plus4),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_rd_data    (o_rd_data)
    );

    rv_alu u_alu (
        .i_op        (alu_op),
        .i_a_sel_pc  (a_sel_pc),
        .i_b_sel_imm (b_sel_imm),
        .i_pc        (pc),
        .i_rs1       (rs1),
        .i_rs2       (rs2),
        .i_imm       (imm),
        .o_result    (alu_result),
        .o_eq        (eq),
        .o_lt        (lt),
        .o_ltu       (ltu)
    );

    rv_imm_gen u_imm_gen (
        .i_inst (inst),
        .i_fmt  (imm_fmt),
        .o_imm  (imm)
    );

    // effective address from the alu, store data from rs2
    rv_data_mem u_data_mem (
        .clk        (clk),
        .i_we       (mem_we),
        .i_size     (mem_size),
        .i_unsigned (mem_unsigned),
        .i_addr     (alu_result),
        .i_wdata    (rs2),
        .o_rdata    (load_data)
    );

    assign o_pc   = pc;
    assign o_inst = inst;

endmodule

//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

    // memory depths, addresses wrap modulo these
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_BYTES = 1024;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_BYTES);

    // data word, instruction or address
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // rv32i major opcodes in use
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // pass_b feeds the immediate straight through for lui
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;

    // encoding follows funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE = 2'd0, MEM_HALF = 2'd1, MEM_WORD = 2'd2} mem_size_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JUMP} br_kind_e;

    typedef enum logic [1:0] {ST_SETUP, ST_RUN, ST_HALTED} ctrl_state_e;

endpackage

//--- verilog/rv_data_mem.sv
`timescale 1ns/1ps

module rv_data_mem (
    input  logic                   clk,
    input  logic                   i_we,
    input  rv_core_pkg::mem_size_e i_size,
    input  logic                   i_unsigned,
    input  rv_core_pkg::word_t     i_addr,
    input  rv_core_pkg::word_t     i_wdata,
    output rv_core_pkg::word_t     o_rdata
);

    logic [7:0] mem [rv_core_pkg::DMEM_BYTES];

    // byte lanes, address wraps at the top of the array
    logic [rv_core_pkg::DMEM_AW-1:0] a0, a1, a2, a3;
    logic [7:0] b0, b1, b2, b3;

    assign a0 = i_addr[rv_core_pkg::DMEM_AW-1:0];
    assign a1 = a0 + 1'b1;
    assign a2 = a0 + 2'd2;
    assign a3 = a0 + 2'd3;

    // little endian, lowest address is lsb
    assign b0 = mem[a0];
    assign b1 = mem[a1];
    assign b2 = mem[a2];
    assign b3 = mem[a3];

    // sign or zero extension on load
    always_comb begin
        case (i_size)
            rv_core_pkg::MEM_BYTE: o_rdata = {{24{!i_unsigned && b0[7]}}, b0};
            rv_core_pkg::MEM_HALF: o_rdata = {{16{!i_unsigned && b1[7]}}, b1, b0};
            default:               o_rdata = {b3, b2, b1, b0};
        endcase
    end

    // stores write only the low 1, 2 or 4 bytes
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[a0] <= i_wdata[7:0];
            if (i_size != rv_core_pkg::MEM_BYTE) begin
                mem[a1] <= i_wdata[15:8];
            end
            if (i_size == rv_core_pkg::MEM_WORD) begin
                mem[a2] <= i_wdata[23:16];
                mem[a3] <= i_wdata[31:24];
            end
        end
    end

endmodule

//--- verilog/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
    input  rv_core_pkg::word_t    i_inst,
    input  rv_core_pkg::imm_fmt_e i_fmt,
    output rv_core_pkg::word_t    o_imm
);

    // sign bit sits at inst[31] for every format
    logic sgn;

    assign sgn = i_inst[31];

    always_comb begin
        case (i_fmt)
            rv_core_pkg::IMM_I: o_imm = {{20{sgn}}, i_inst[31:20]};
            rv_core_pkg::IMM_S: o_imm = {{20{sgn}}, i_inst[31:25], i_inst[11:7]};
            // b and j keep bit 0 clear
            rv_core_pkg::IMM_B: begin
                o_imm = {{19{sgn}}, sgn, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            end
            rv_core_pkg::IMM_U: o_imm = {i_inst[31:12], 12'd0};
            rv_core_pkg::IMM_J: begin
                o_imm = {{11{sgn}}, sgn, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
            end
            default:            o_imm = '0;
        endcase
    end

endmodule

//--- verilog/rv_inst_mem.sv
`timescale 1ns/1ps

module rv_inst_mem (
    input  logic               clk,
    input  logic               i_we,
    input  rv_core_pkg::word_t i_waddr,
    input  rv_core_pkg::word_t i_wdata,
    input  rv_core_pkg::word_t i_pc,
    output rv_core_pkg::word_t o_inst
);

    rv_core_pkg::word_t mem [rv_core_pkg::IMEM_WORDS];

    // word index from byte address, upper bits wrap
    logic [rv_core_pkg::IMEM_AW-1:0] widx, ridx;

    assign widx = i_waddr[rv_core_pkg::IMEM_AW+1:2];
    assign ridx = i_pc[rv_core_pkg::IMEM_AW+1:2];

    // loaded one word per clock during setup
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[widx] <= i_wdata;
        end
    end

    // async fetch
    assign o_inst = mem[ridx];

endmodule

//--- verilog/rv_pc.sv
`timescale 1ns/1ps

module rv_pc (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic               i_load_start,
    input  rv_core_pkg::word_t i_start_addr,
    input  logic               i_stall,
    input  logic               i_take_branch,
    input  logic               i_target_from_alu,
    input  rv_core_pkg::word_t i_imm,
    input  rv_core_pkg::word_t i_alu_result,
    output rv_core_pkg::word_t o_pc,
    output rv_core_pkg::word_t o_pc_plus4
);

    rv_core_pkg::word_t target;

    assign o_pc_plus4 = o_pc + 32'd4;
    // jalr drops bit 0 of the computed address
    assign target = i_target_from_alu ? {i_alu_result[31:1], 1'b0} : o_pc + i_imm;

    // start load beats stall, stall beats branch
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= '0;
        end else if (i_load_start) begin
            o_pc <= i_start_addr;
        end else if (!i_stall) begin
            o_pc <= i_take_branch ? target : o_pc_plus4;
        end
    end

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_we,
    input  rv_core_pkg::reg_addr_t i_rd_addr,
    input  rv_core_pkg::reg_addr_t i_rs1_addr,
    input  rv_core_pkg::reg_addr_t i_rs2_addr,
    input  rv_core_pkg::wb_sel_e   i_wb_sel,
    input  rv_core_pkg::word_t     i_alu_result,
    input  rv_core_pkg::word_t     i_load_data,
    input  rv_core_pkg::word_t     i_link,
    output rv_core_pkg::word_t     o_rs1,
    output rv_core_pkg::word_t     o_rs2,
    output rv_core_pkg::word_t     o_rd_data
);

    rv_core_pkg::word_t regs [32];

    // writeback source
    always_comb begin
        case (i_wb_sel)
            rv_core_pkg::WB_LOAD: o_rd_data = i_load_data;
            rv_core_pkg::WB_LINK: o_rd_data = i_link;
            default:              o_rd_data = i_alu_result;
        endcase
    end

    // x0 never written so it always reads zero
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd_addr != 5'd0)) begin
            regs[i_rd_addr] <= o_rd_data;
        end
    end

    assign o_rs1 = regs[i_rs1_addr];
    assign o_rs2 = regs[i_rs2_addr];

endmodule
